//--- hdl/dbg_cmd_pkg.sv
// CPU-side definitions of the debug module
// Command opcodes, data register field positions and the SPR bus request.
// Modules refer to these by scoped name
package dbg_cmd_pkg;

  // Command opcodes in bits 51:48 of the data register
  typedef enum logic [3:0] {
    BWRITE32 = 4'd3,   // Burst write of 32-bit words
    BREAD32  = 4'd7,   // Burst read of 32-bit words
    IREG_WR  = 4'd9,   // Write the control register
    IREG_SEL = 4'd13   // Select internal register, only one exists
  } dbg_opcode_e;

  localparam int DR_WIDTH   = 53;  // TAP data register width

  // Field positions in the data register
  localparam int TOP_BIT    = 52;  // 0 = command for this module
  localparam int OP_MSB     = 51;
  localparam int OP_LSB     = 48;
  localparam int ADDR_MSB   = 47;
  localparam int ADDR_LSB   = 16;
  localparam int CNT_LSB    = 0;   // Word count starts here
  localparam int RST_BIT    = 46;  // IREG_WR reset bit
  localparam int STALL_BIT  = 45;  // IREG_WR stall bit

  localparam int SPR_AW     = 32;
  localparam int SPR_DW     = 32;
  localparam int WORD_CNT_W = 16;

  // Request toward the CPU SPR bus
  typedef struct packed {
    logic [SPR_AW-1:0] addr;
    logic [SPR_DW-1:0] wdata;
    logic              we;   // 1 = write
    logic              stb;  // Held until ack
  } spr_req_t;

endpackage

//--- hdl/dbg_tap_pkg.sv
// JTAG-side definitions of the debug module
// TAP control bundle, burst FSM states and the TDO source select
package dbg_tap_pkg;

  // TAP controller signals seen by the module
  typedef struct packed {
    logic sel;      // Module selected by the top level
    logic capture;  // Capture-DR
    logic shift;    // Shift-DR
    logic update;   // Update-DR
  } tap_ctrl_t;

  typedef enum logic [3:0] {
    IDLE,
    RBEGIN,   // First read strobe
    RREADY,   // Wait for capture
    RSTATUS,  // Ready bits on TDO
    RBURST,
    RCRC,     // CRC out until update
    WREADY,   // Wait for capture
    WWAIT,    // Wait for start bit
    WBURST,
    WCRC,     // CRC in
    WMATCH    // Match bit until update
  } burst_state_e;

  typedef enum logic [1:0] {
    READY,  // Bus ready bit
    DATA,   // Output shift register LSB
    MATCH,  // CRC compare result
    CRC     // Serial CRC
  } tdo_sel_e;

endpackage

//--- hdl/dbg_crc32.sv
// Serial CRC-32 for the debug module
// Reflected polynomial EDB88320, starts at all ones, no final inversion.
// Shifting rotates the register so it also serves as the CRC output
`timescale 1ns/100ps

module dbg_crc32 (
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        clr_i,     // Back to all ones
  input  logic        en_i,      // Take one bit
  input  logic        bit_i,
  input  logic        shift_i,   // Rotate out the LSB
  output logic [31:0] crc_o,
  output logic        serial_o
);

  localparam logic [31:0] POLY = 32'hEDB8_8320;

  logic [31:0] crc_q;
  logic        fb;                  // Feedback bit

  assign fb = crc_q[0] ^ bit_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;
    end else if (en_i) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? POLY : 32'h0);
    end else if (shift_i) begin
      crc_q <= {crc_q[0], crc_q[31:1]};
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];   // LSB first on TDO

endmodule

//--- hdl/dbg_cpu_ctrl_reg.sv
// CPU control register of the debug module
// Holds the stall and reset bits driven to the CPU. A breakpoint sets stall
`timescale 1ns/100ps

module dbg_cpu_ctrl_reg (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       wr_i,          // IREG_WR pulse
  input  logic [1:0] wdata_i,       // {reset, stall}
  input  logic       bp_i,          // Breakpoint hit
  output logic [1:0] status_o,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  logic stall_q;
  logic rst_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q <= 1'b0;
      rst_q   <= 1'b0;
    end else begin
      if (wr_i) rst_q <= wdata_i[1];
      if (bp_i) begin
        stall_q <= 1'b1;            // Breakpoint wins over a write
      end else if (wr_i) begin
        stall_q <= wdata_i[0];
      end
    end
  end

  assign status_o    = {rst_q, stall_q};
  assign cpu_stall_o = stall_q;
  assign cpu_rst_o   = rst_q;

endmodule

//--- hdl/dbg_spr_bus_unit.sv
// SPR bus unit of the CPU debug module
// Takes one access per strobe from the burst FSM and runs the strobe and
// acknowledge cycle on the SPR bus. Ready is high when nothing is pending
`timescale 1ns/100ps

module dbg_spr_bus_unit (
  input  logic                            tck_i,
  input  logic                            rst_i,
  input  logic                            strobe_i,    // One-cycle start
  input  logic [dbg_cmd_pkg::SPR_AW-1:0]  addr_i,
  input  logic [dbg_cmd_pkg::SPR_DW-1:0]  wdata_i,
  input  logic                            rd_i,
  output logic                            ready_o,
  output logic [dbg_cmd_pkg::SPR_DW-1:0]  rdata_o,
  output dbg_cmd_pkg::spr_req_t           spr_req_o,
  input  logic [dbg_cmd_pkg::SPR_DW-1:0]  cpu_data_i,
  input  logic                            cpu_ack_i
);

  logic [dbg_cmd_pkg::SPR_AW-1:0] addr_q;
  logic [dbg_cmd_pkg::SPR_DW-1:0] wdata_q;
  logic [dbg_cmd_pkg::SPR_DW-1:0] rdata_q;
  logic                           we_q;
  logic                           stb_q;
  logic                           ready_q;

  // Payload, held for the whole request
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (stb_q && cpu_ack_i && !we_q) rdata_q <= cpu_data_i;  // Read data on ack
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q   <= 1'b0;
      we_q    <= 1'b0;
      ready_q <= 1'b1;
    end else if (strobe_i) begin
      stb_q   <= 1'b1;
      we_q    <= !rd_i;
      ready_q <= 1'b0;
    end else if (stb_q && cpu_ack_i) begin
      stb_q   <= 1'b0;                     // Drop the cycle after ack
      we_q    <= 1'b0;
      ready_q <= 1'b1;
    end
  end

  assign spr_req_o = '{addr: addr_q, wdata: wdata_q, we: we_q, stb: stb_q};
  assign ready_o   = ready_q;
  assign rdata_o   = rdata_q;

endmodule

//--- hdl/dbg_burst_ctrl.sv
// Burst FSM of the CPU debug module
// Decodes commands from the TAP data register, runs burst reads and writes
// over the SPR bus unit and drives TDO. Address, word and bit counters and
// the output shift register live here
`timescale 1ns/100ps

module dbg_burst_ctrl #(
  parameter int MAX_WORD_CNT_W = 16
) (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  dbg_tap_pkg::tap_ctrl_t            tap_i,
  input  logic                              tdi_i,
  input  logic [dbg_cmd_pkg::DR_WIDTH-1:0]  data_register_i,
  output logic                              bus_strobe_o,
  output logic [dbg_cmd_pkg::SPR_AW-1:0]    bus_addr_o,
  output logic [dbg_cmd_pkg::SPR_DW-1:0]    bus_wdata_o,
  output logic                              bus_rd_o,
  input  logic                              bus_ready_i,
  input  logic [dbg_cmd_pkg::SPR_DW-1:0]    bus_rdata_i,
  output logic                              crc_clr_o,
  output logic                              crc_en_o,
  output logic                              crc_bit_o,
  output logic                              crc_shift_o,
  input  logic [31:0]                       crc_value_i,
  input  logic                              crc_serial_i,
  output logic                              ctrl_wr_o,
  input  logic [1:0]                        ctrl_status_i,
  output logic                              tdo_o,
  output logic                              top_inhibit_o
);

  localparam int TOP = dbg_cmd_pkg::TOP_BIT;
  localparam int DW  = dbg_cmd_pkg::SPR_DW;

  dbg_tap_pkg::burst_state_e  state_q, state_d;
  dbg_tap_pkg::tdo_sel_e      tdo_sel;
  dbg_cmd_pkg::dbg_opcode_e   op_in;       // Opcode field, decoded before latching

  logic [dbg_cmd_pkg::SPR_AW-1:0] addr_q;  // Next SPR address
  logic [MAX_WORD_CNT_W-1:0]      word_q;  // Words still to load
  logic [5:0]                     bit_q;   // Bits in current word or CRC
  logic [DW-1:0]                  out_q;   // Parallel-load output shift register

  logic cmd_take;                          // Module command on update
  logic word_zero, word_last, bit_max, bit_32, crc_match;
  logic load_cmd, word_dec, bit_rst, bit_inc;
  logic out_ld, out_ld_ctrl, out_shift;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign op_in     = dbg_cmd_pkg::dbg_opcode_e'(
                       data_register_i[dbg_cmd_pkg::OP_MSB:dbg_cmd_pkg::OP_LSB]);
  assign cmd_take  = tap_i.sel && tap_i.update && !data_register_i[TOP];
  assign word_zero = (word_q == '0);
  assign word_last = (word_q == MAX_WORD_CNT_W'(1));  // Last access already issued
  assign bit_max   = (bit_q == 6'd31);
  assign bit_32    = (bit_q == 6'd32);
  assign crc_match = (data_register_i[TOP -: 32] == crc_value_i);

  // Read path states feed TDO data into the CRC
  assign bus_rd_o  = state_q inside {dbg_tap_pkg::RBEGIN, dbg_tap_pkg::RREADY,
                                     dbg_tap_pkg::RSTATUS, dbg_tap_pkg::RBURST,
                                     dbg_tap_pkg::RCRC};
  assign crc_bit_o = bus_rd_o ? out_q[0] : tdi_i;

  // 32nd write bit is still on TDI, the other 31 sit in the data register
  assign bus_wdata_o = {tdi_i, data_register_i[TOP -: DW-1]};
  assign bus_addr_o  = addr_q;
  assign crc_clr_o   = load_cmd;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    tdo_sel       = dbg_tap_pkg::DATA;
    top_inhibit_o = 1'b0;
    bus_strobe_o  = 1'b0;
    crc_en_o      = 1'b0;
    crc_shift_o   = 1'b0;
    ctrl_wr_o     = 1'b0;
    load_cmd      = 1'b0;
    word_dec      = 1'b0;
    bit_rst       = 1'b0;
    bit_inc       = 1'b0;
    out_ld        = 1'b0;
    out_ld_ctrl   = 1'b0;
    out_shift     = 1'b0;

    case (state_q)
      dbg_tap_pkg::IDLE: begin
        out_ld      = tap_i.sel && tap_i.capture;  // Control status readback
        out_ld_ctrl = 1'b1;
        out_shift   = tap_i.sel && tap_i.shift;
        ctrl_wr_o   = cmd_take && (op_in == dbg_cmd_pkg::IREG_WR);
        if (cmd_take && op_in == dbg_cmd_pkg::BREAD32) begin
          state_d = dbg_tap_pkg::RBEGIN;
        end else if (cmd_take && op_in == dbg_cmd_pkg::BWRITE32) begin
          state_d = dbg_tap_pkg::WREADY;
        end
        load_cmd = (state_d != dbg_tap_pkg::IDLE);  // Counters and CRC cleared here
        bit_rst  = load_cmd;
      end
      dbg_tap_pkg::RBEGIN: begin
        if (word_zero) begin
          state_d = dbg_tap_pkg::IDLE;     // Empty burst
        end else begin
          bus_strobe_o = 1'b1;             // First read starts now
          state_d      = dbg_tap_pkg::RREADY;
        end
      end
      dbg_tap_pkg::RREADY: begin
        if (tap_i.sel && tap_i.capture) state_d = dbg_tap_pkg::RSTATUS;
      end
      dbg_tap_pkg::RSTATUS: begin
        tdo_sel       = dbg_tap_pkg::READY;
        top_inhibit_o = 1'b1;
        if (bus_ready_i) begin
          state_d      = dbg_tap_pkg::RBURST;
          out_ld       = 1'b1;
          bit_rst      = 1'b1;
          word_dec     = 1'b1;
          bus_strobe_o = !word_last;       // Fetch next word ahead
        end
      end
      dbg_tap_pkg::RBURST: begin
        top_inhibit_o = 1'b1;
        out_shift     = 1'b1;
        bit_inc       = 1'b1;
        crc_en_o      = 1'b1;
        if (bit_max && word_zero) begin
          state_d = dbg_tap_pkg::RCRC;
        end else if (bit_max) begin
          out_ld       = 1'b1;
          bit_rst      = 1'b1;
          word_dec     = 1'b1;
          bus_strobe_o = !word_last;
        end
      end
      dbg_tap_pkg::RCRC: begin
        tdo_sel       = dbg_tap_pkg::CRC;  // Shifts until update
        crc_shift_o   = 1'b1;
        top_inhibit_o = 1'b1;
      end
      dbg_tap_pkg::WREADY: begin
        if (word_zero) begin
          state_d = dbg_tap_pkg::IDLE;
        end else if (tap_i.sel && tap_i.capture) begin
          state_d = dbg_tap_pkg::WWAIT;
        end
      end
      dbg_tap_pkg::WWAIT: begin
        top_inhibit_o = 1'b1;
        // Start bit is in the register, first data bit is on TDI
        if (tap_i.sel && tap_i.shift && data_register_i[TOP]) begin
          state_d  = dbg_tap_pkg::WBURST;
          bit_inc  = 1'b1;
          word_dec = 1'b1;
          crc_en_o = 1'b1;
        end
      end
      dbg_tap_pkg::WBURST: begin
        top_inhibit_o = 1'b1;
        bit_inc       = 1'b1;
        crc_en_o      = 1'b1;
        if (bit_max) begin
          bus_strobe_o = 1'b1;             // Word complete
          bit_rst      = 1'b1;
          word_dec     = !word_zero;
          if (word_zero) state_d = dbg_tap_pkg::WCRC;
        end
      end
      dbg_tap_pkg::WCRC: begin
        top_inhibit_o = 1'b1;
        bit_inc       = 1'b1;
        if (bit_32) begin
          state_d = dbg_tap_pkg::WMATCH;
          tdo_sel = dbg_tap_pkg::MATCH;    // Host reads the match bit here
        end
      end
      dbg_tap_pkg::WMATCH: begin
        tdo_sel       = dbg_tap_pkg::MATCH;
        top_inhibit_o = 1'b1;
      end
      default: state_d = dbg_tap_pkg::IDLE;
    endcase

    // Update ends any burst early
    if (state_q != dbg_tap_pkg::IDLE && tap_i.update) state_d = dbg_tap_pkg::IDLE;
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_tap_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Counters and shift register
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
    end else begin
      if (load_cmd) begin
        addr_q <= data_register_i[dbg_cmd_pkg::ADDR_MSB:dbg_cmd_pkg::ADDR_LSB];
      end else if (bus_strobe_o) begin
        addr_q <= addr_q + 1'b1;           // SPRs are word addressed
      end
      if (load_cmd) begin
        word_q <= data_register_i[dbg_cmd_pkg::CNT_LSB +: MAX_WORD_CNT_W];
      end else if (word_dec) begin
        word_q <= word_q - 1'b1;
      end
      if (bit_rst) begin
        bit_q <= '0;
      end else if (bit_inc) begin
        bit_q <= bit_q + 1'b1;
      end
    end
  end

  always_ff @(posedge tck_i) begin
    if (out_ld) begin
      out_q <= out_ld_ctrl ? {{(DW-2){1'b0}}, ctrl_status_i} : bus_rdata_i;
    end else if (out_shift) begin
      out_q <= {1'b0, out_q[DW-1:1]};      // LSB first
    end
  end

  // TDO source
  always_comb begin
    case (tdo_sel)
      dbg_tap_pkg::READY: tdo_o = bus_ready_i;
      dbg_tap_pkg::MATCH: tdo_o = crc_match;
      dbg_tap_pkg::CRC:   tdo_o = crc_serial_i;
      default:            tdo_o = out_q[0];
    endcase
  end

endmodule

//--- hdl/dbg_cpu_module.sv
// CPU debug module top level
// Connects the burst FSM, the SPR bus unit, the CRC and the control
// register. Sits behind the JTAG TAP, everything runs on TCK
`timescale 1ns/100ps

module dbg_cpu_module #(
  parameter int MAX_WORD_CNT_W = dbg_cmd_pkg::WORD_CNT_W  // Burst length counter width
) (
  input  logic                                tck_i,
  input  logic                                rst_i,
  // TAP side
  input  logic                                tdi_i,
  input  logic [dbg_cmd_pkg::DR_WIDTH-1:0]    data_register_i,
  input  dbg_tap_pkg::tap_ctrl_t              tap_i,
  output logic                                tdo_o,
  output logic                                top_inhibit_o,
  // CPU side
  output dbg_cmd_pkg::spr_req_t               spr_req_o,
  input  logic [dbg_cmd_pkg::SPR_DW-1:0]      cpu_data_i,
  input  logic                                cpu_ack_i,
  input  logic                                cpu_bp_i,
  output logic                                cpu_stall_o,
  output logic                                cpu_rst_o
);

  logic                             bus_strobe;   // One-cycle access request
  logic [dbg_cmd_pkg::SPR_AW-1:0]   bus_addr;
  logic [dbg_cmd_pkg::SPR_DW-1:0]   bus_wdata;
  logic [dbg_cmd_pkg::SPR_DW-1:0]   bus_rdata;
  logic                             bus_rd;
  logic                             bus_ready;
  logic                             crc_clr;
  logic                             crc_en;
  logic                             crc_bit;
  logic                             crc_shift;
  logic                             crc_serial;
  logic [31:0]                      crc_value;
  logic                             ctrl_wr;
  logic [1:0]                       ctrl_status;  // {reset, stall}

  dbg_burst_ctrl #(
    .MAX_WORD_CNT_W (MAX_WORD_CNT_W)
  ) u_burst_ctrl (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tap_i           (tap_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .bus_strobe_o    (bus_strobe),
    .bus_addr_o      (bus_addr),
    .bus_wdata_o     (bus_wdata),
    .bus_rd_o        (bus_rd),
    .bus_ready_i     (bus_ready),
    .bus_rdata_i     (bus_rdata),
    .crc_clr_o       (crc_clr),
    .crc_en_o        (crc_en),
    .crc_bit_o       (crc_bit),
    .crc_shift_o     (crc_shift),
    .crc_value_i     (crc_value),
    .crc_serial_i    (crc_serial),
    .ctrl_wr_o       (ctrl_wr),
    .ctrl_status_i   (ctrl_status),
    .tdo_o           (tdo_o),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_spr_bus_unit u_spr_bus_unit (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .strobe_i   (bus_strobe),
    .addr_i     (bus_addr),
    .wdata_i    (bus_wdata),
    .rd_i       (bus_rd),
    .ready_o    (bus_ready),
    .rdata_o    (bus_rdata),
    .spr_req_o  (spr_req_o),
    .cpu_data_i (cpu_data_i),
    .cpu_ack_i  (cpu_ack_i)
  );

  dbg_crc32 u_crc32 (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clr_i    (crc_clr),
    .en_i     (crc_en),
    .bit_i    (crc_bit),
    .shift_i  (crc_shift),
    .crc_o    (crc_value),
    .serial_o (crc_serial)
  );

  // Reset and stall bits come straight from the IREG_WR command
  dbg_cpu_ctrl_reg u_ctrl_reg (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .wr_i        (ctrl_wr),
    .wdata_i     (data_register_i[dbg_cmd_pkg::RST_BIT:dbg_cmd_pkg::STALL_BIT]),
    .bp_i        (cpu_bp_i),
    .status_o    (ctrl_status),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

endmodule

//--- sim/dbg_cpu_checker.sv
// Concurrent assertions for the CPU debug module
// Bound into the module top, where the SPR bus unit's request, the ack and
// the inhibit output all meet. Failures are counted for the testbench
`timescale 1ns/100ps

module dbg_cpu_checker (
  input logic        tck_i,
  input logic        rst_i,
  input logic        stb_i,       // SPR request strobe
  input logic        ack_i,       // SPR acknowledge
  input logic [31:0] addr_i,      // SPR request address
  input logic        idle_i,      // Burst FSM in IDLE
  input logic        inhibit_i    // Top-level TAP inhibit
);

  int assert_fails = 0;           // Read by the testbench summary

  // Address held while the request waits for ack
  addr_hold_a: assert property (@(posedge tck_i) disable iff (rst_i)
    stb_i && !ack_i |=> $stable(addr_i))
    else begin
      $error("SPR address changed while the request was pending");
      assert_fails++;
    end

  // Strobe gone one cycle after ack
  stb_drop_a: assert property (@(posedge tck_i) disable iff (rst_i)
    stb_i && ack_i |=> !stb_i)
    else begin
      $error("SPR strobe still high after acknowledge");
      assert_fails++;
    end

  idle_inhibit_a: assert property (@(posedge tck_i) disable iff (rst_i)
    idle_i |-> !inhibit_i)
    else begin
      $error("Top-level inhibit high while the burst FSM is idle");
      assert_fails++;
    end

endmodule

bind dbg_cpu_module dbg_cpu_checker chk0 (
  .tck_i     (tck_i),
  .rst_i     (rst_i),
  .stb_i     (spr_req_o.stb),
  .ack_i     (cpu_ack_i),
  .addr_i    (spr_req_o.addr),
  .idle_i    (u_burst_ctrl.state_q == dbg_tap_pkg::IDLE),
  .inhibit_i (top_inhibit_o)
);

//--- sim/tb_dbg_cpu_module.sv
// Testbench for the CPU debug module
// Models the TAP data register bit by bit and answers the SPR bus from a
// small memory with random acknowledge delay. Runs reset, control register,
// burst write, burst read and inhibit tests, then prints a summary
`timescale 1ns/100ps

module tb_dbg_cpu_module;

  localparam int NW_WR   = 4;   // Words per write burst
  localparam int NW_RD   = 3;   // Words per read burst
  localparam int CMD_CYC = 55;  // Command shift, update and idle
  // Rough cycle count of all tests, the watchdog allows four times this
  localparam int TEST_CYC = 10 + (4 * CMD_CYC + 20) + 2 * (CMD_CYC + 40 + 32 * NW_WR)
                          + (CMD_CYC + 110 + 32 * NW_RD) + (CMD_CYC + 30);

  logic                                 tck = 1'b0;
  logic                                 rst;
  logic                                 tdi;
  logic [dbg_cmd_pkg::DR_WIDTH-1:0]     dr;          // TAP data register model
  dbg_tap_pkg::tap_ctrl_t               tap;
  logic                                 tdo;
  logic                                 inhibit;
  dbg_cmd_pkg::spr_req_t                spr_req;
  logic [31:0]                          cpu_data;
  logic                                 cpu_ack;
  logic                                 cpu_bp;
  logic                                 cpu_stall;
  logic                                 cpu_rst;

  integer      seed = 32'hd255;
  logic [31:0] mem [0:255];                          // SPR space by low address byte
  logic [31:0] log_addr [$];                         // Writes seen on the bus
  logic [31:0] log_data [$];
  int          ack_cnt;
  logic [31:0] wr_words [NW_WR];
  logic [31:0] rd_exp [NW_RD];
  logic [31:0] rd_words [NW_RD];
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  string       cmp_name;
  logic [31:0] cmp_got;
  logic [31:0] cmp_exp;
  logic        cmp_req = 1'b0;                       // Compare handshake

  dbg_cpu_module #(
    .MAX_WORD_CNT_W (dbg_cmd_pkg::WORD_CNT_W)
  ) dut0 (
    .tck_i           (tck),
    .rst_i           (rst),
    .tdi_i           (tdi),
    .data_register_i (dr),
    .tap_i           (tap),
    .tdo_o           (tdo),
    .top_inhibit_o   (inhibit),
    .spr_req_o       (spr_req),
    .cpu_data_i      (cpu_data),
    .cpu_ack_i       (cpu_ack),
    .cpu_bp_i        (cpu_bp),
    .cpu_stall_o     (cpu_stall),
    .cpu_rst_o       (cpu_rst)
  );

  always #4 tck = ~tck;                              // 8 ns TCK

  // Shift-DR moves TDI into bit 52
  always @(posedge tck) begin
    if (tap.shift) dr <= {tdi, dr[dbg_cmd_pkg::DR_WIDTH-1:1]};
  end

  //////////////////////////////
  // SPR memory model
  //////////////////////////////

  always @(posedge tck or posedge rst) begin
    if (rst) begin
      cpu_ack <= 1'b0;
      ack_cnt <= 0;
    end else if (cpu_ack) begin
      cpu_ack <= 1'b0;                               // Single-cycle ack
    end else if (spr_req.stb) begin
      if (ack_cnt == 0) begin
        ack_cnt <= 1 + ({$random(seed)} % 8);        // New request, 1 to 8 cycles
      end else if (ack_cnt == 1) begin
        ack_cnt <= 0;
        cpu_ack <= 1'b1;
        if (spr_req.we) begin
          mem[spr_req.addr[7:0]] <= spr_req.wdata;
          log_addr.push_back(spr_req.addr);
          log_data.push_back(spr_req.wdata);
        end else begin
          cpu_data <= mem[spr_req.addr[7:0]];
        end
      end else begin
        ack_cnt <= ack_cnt - 1;
      end
    end
  end

  // Compare process, one check per request
  always begin
    wait (cmp_req);
    checks++;
    if (cmp_got !== cmp_exp) begin
      $display("CHECK FAILED %s got %h expected %h", cmp_name, cmp_got, cmp_exp);
      errors++;
    end
    cmp_req = 1'b0;
  end

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  function automatic logic [dbg_cmd_pkg::DR_WIDTH-1:0] make_cmd(input logic [3:0] op,
      input logic [31:0] addr, input logic [15:0] cnt);
    return {1'b0, op, addr, cnt};                    // Bit 52 low, for this module
  endfunction

  // Reflected CRC-32 over one word, LSB first
  function automatic logic [31:0] crc32_word(input logic [31:0] crc, input logic [31:0] data);
    logic [31:0] c;
    int          i;
    c = crc;
    for (i = 0; i < 32; i++) begin
      if (c[0] ^ data[i]) c = (c >> 1) ^ 32'hEDB8_8320;
      else c = c >> 1;
    end
    return c;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    cmp_name = name;
    cmp_got  = got;
    cmp_exp  = exp;
    cmp_req  = 1'b1;
    wait (!cmp_req);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      tests_bad++;
      $display("FAIL %s with %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////////////
  // TAP model
  //////////////////////////////

  // One TCK cycle, TDO sampled at the falling edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd, input logic b,
      output logic t);
    @(posedge tck);
    tap.capture <= cap;
    tap.shift   <= sh;
    tap.update  <= upd;
    tdi         <= b;
    @(negedge tck);
    t = tdo;
  endtask

  task automatic send_command(input logic [dbg_cmd_pkg::DR_WIDTH-1:0] cmd);
    logic t;
    int   i;
    for (i = 0; i < dbg_cmd_pkg::DR_WIDTH; i++) tap_cycle(1'b0, 1'b1, 1'b0, cmd[i], t);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);            // Update
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);            // Run-test-idle
  endtask

  task automatic read_ctrl(output logic [1:0] st);
    logic t;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);            // Capture loads status
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, st[0]);        // Stall
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, st[1]);        // Reset
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic pulse_bp();
    @(posedge tck);
    cpu_bp <= 1'b1;
    @(posedge tck);
    cpu_bp <= 1'b0;
    @(negedge tck);
  endtask

  task automatic write_burst(input logic [31:0] addr, input int n, input logic [31:0] flip,
      output logic match, output logic inh);
    logic        t;
    logic [31:0] crc;
    int          w;
    int          i;
    crc = 32'hFFFF_FFFF;
    send_command(make_cmd(dbg_cmd_pkg::BWRITE32, addr, 16'(n)));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);            // Capture
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);            // Start bit
    for (w = 0; w < n; w++) begin
      for (i = 0; i < 32; i++) tap_cycle(1'b0, 1'b1, 1'b0, wr_words[w][i], t);
      crc = crc32_word(crc, wr_words[w]);
    end
    inh = inhibit;                                   // Still in the data phase
    crc = crc ^ flip;
    for (i = 0; i < 32; i++) tap_cycle(1'b0, 1'b1, 1'b0, crc[i], t);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, match);        // Match bit on TDO
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic read_burst(input logic [31:0] addr, input int n, output logic [31:0] crc_got,
      output logic [31:0] crc_ref);
    logic        t;
    logic [31:0] word;
    int          w;
    int          i;
    int          waits;
    send_command(make_cmd(dbg_cmd_pkg::BREAD32, addr, 16'(n)));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    t     = 1'b0;
    waits = 0;
    while (!t && waits < 64) begin                   // Skip ready bits up to the first 1
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
      waits++;
    end
    if (!t) begin
      $display("Read burst never showed the ready bit");
      errors++;
    end
    crc_ref = 32'hFFFF_FFFF;
    for (w = 0; w < n; w++) begin
      for (i = 0; i < 32; i++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
        word[i] = t;
      end
      rd_words[w] = word;
      crc_ref     = crc32_word(crc_ref, word);       // Over the bits as read
    end
    for (i = 0; i < 32; i++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
      crc_got[i] = t;
    end
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    int          e0;
    int          i;
    logic        match;
    logic        inh;
    logic        t;
    logic [1:0]  st;
    logic [31:0] crc_got;
    logic [31:0] crc_ref;
    rst      = 1'b1;
    tdi      = 1'b0;
    dr       = '0;
    tap      = '{sel: 1'b1, capture: 1'b0, shift: 1'b0, update: 1'b0};
    cpu_data = '0;
    cpu_ack  = 1'b0;
    cpu_bp   = 1'b0;
    for (i = 0; i < 256; i++) mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
    repeat (3) @(posedge tck);
    rst <= 1'b0;
    @(negedge tck);

    e0 = errors;
    expect_eq("spr_req_o.stb", spr_req.stb, 32'h0);
    expect_eq("spr_req_o.we", spr_req.we, 32'h0);
    expect_eq("cpu_stall_o", cpu_stall, 32'h0);
    expect_eq("cpu_rst_o", cpu_rst, 32'h0);
    expect_eq("top_inhibit_o", inhibit, 32'h0);
    finish_test("reset values", e0);

    e0 = errors;
    send_command(make_cmd(dbg_cmd_pkg::IREG_WR, {1'b0, 1'b1, 1'b1, 29'd0}, 16'd0));
    expect_eq("cpu_stall_o", cpu_stall, 32'h1);
    expect_eq("cpu_rst_o", cpu_rst, 32'h1);
    read_ctrl(st);
    expect_eq("ctrl status (tdo_o)", st, 32'h3);
    send_command(make_cmd(dbg_cmd_pkg::IREG_WR, 32'h0, 16'd0));
    expect_eq("cpu_stall_o", cpu_stall, 32'h0);
    expect_eq("cpu_rst_o", cpu_rst, 32'h0);
    pulse_bp();                                      // Breakpoint sets stall only
    expect_eq("cpu_stall_o", cpu_stall, 32'h1);
    expect_eq("cpu_rst_o", cpu_rst, 32'h0);
    read_ctrl(st);
    expect_eq("ctrl status (tdo_o)", st, 32'h1);
    send_command(make_cmd(dbg_cmd_pkg::IREG_WR, 32'h0, 16'd0));
    finish_test("control register", e0);

    e0 = errors;
    for (i = 0; i < NW_WR; i++) wr_words[i] = $random(seed);
    log_addr.delete();
    log_data.delete();
    write_burst(32'h0000_3A10, NW_WR, 32'h0, match, inh);
    expect_eq("write count", log_addr.size(), NW_WR);
    for (i = 0; i < NW_WR; i++) begin
      expect_eq("spr_req_o.addr", log_addr[i], 32'h0000_3A10 + i);
      expect_eq("spr_req_o.wdata", log_data[i], wr_words[i]);
    end
    expect_eq("match bit (tdo_o)", match, 32'h1);
    expect_eq("top_inhibit_o", inh, 32'h1);
    expect_eq("top_inhibit_o", inhibit, 32'h0);
    write_burst(32'h0000_3A10, NW_WR, 32'h0000_0001, match, inh);  // Corrupted CRC
    expect_eq("match bit (tdo_o)", match, 32'h0);
    finish_test("burst write", e0);

    e0 = errors;
    for (i = 0; i < NW_RD; i++) begin
      rd_exp[i]                       = $random(seed);
      mem[(32'h0000_0F7E + i) & 8'hFF] = rd_exp[i];
    end
    read_burst(32'h0000_0F7E, NW_RD, crc_got, crc_ref);
    for (i = 0; i < NW_RD; i++) expect_eq("read data (tdo_o)", rd_words[i], rd_exp[i]);
    expect_eq("read crc (tdo_o)", crc_got, crc_ref);
    expect_eq("top_inhibit_o", inhibit, 32'h0);
    finish_test("burst read", e0);

    e0 = errors;
    log_addr.delete();
    send_command(make_cmd(dbg_cmd_pkg::BWRITE32, 32'h0000_0040, 16'd2));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    expect_eq("top_inhibit_o", inhibit, 32'h0);      // Not yet in the data phase
    for (i = 0; i < 11; i++) tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);
    expect_eq("top_inhibit_o", inhibit, 32'h1);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);            // Early stop
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    expect_eq("top_inhibit_o", inhibit, 32'h0);
    expect_eq("write count", log_addr.size(), 32'h0);
    pulse_bp();                                      // Stall to 1 for the readback
    read_ctrl(st);                                   // Readback works only in IDLE
    expect_eq("ctrl status (tdo_o)", st, 32'h1);
    finish_test("inhibit and early stop", e0);

    $display("Summary %0d tests, %0d failing, %0d checks, %0d errors, %0d assertion errors",
             tests_run, tests_bad, checks, errors, dut0.chk0.assert_fails);
    if (errors == 0 && tests_bad == 0 && dut0.chk0.assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TEST_CYC * 4 * 8);
    $display("Watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

endmodule

//--- verilog.f
hdl/dbg_cmd_pkg.sv
hdl/dbg_tap_pkg.sv
hdl/dbg_crc32.sv
hdl/dbg_cpu_ctrl_reg.sv
hdl/dbg_spr_bus_unit.sv
hdl/dbg_burst_ctrl.sv
hdl/dbg_cpu_module.sv
sim/dbg_cpu_checker.sv
sim/tb_dbg_cpu_module.sv

//--- Bender.yml
package:
  name: dbg_cpu_module

sources:
  # Packages first, then leaf modules, then the top level
  - hdl/dbg_cmd_pkg.sv
  - hdl/dbg_tap_pkg.sv
  - hdl/dbg_crc32.sv
  - hdl/dbg_cpu_ctrl_reg.sv
  - hdl/dbg_spr_bus_unit.sv
  - hdl/dbg_burst_ctrl.sv
  - hdl/dbg_cpu_module.sv

  - target: simulation
    files:
      - sim/dbg_cpu_checker.sv
      - sim/tb_dbg_cpu_module.sv
